/* verilog/loader_pkg.sv */
// Shared constants and types for the UART memory loader.
// Every stage refers to these by scoped name (loader_pkg::name).

package loader_pkg;

// Data word and word-address widths.
localparam int xlen   = 32;
localparam int addr_w = 8;

// Command opcodes sent by the host.
localparam logic [7:0] OPC_WRITE = 8'h01;
localparam logic [7:0] OPC_READ  = 8'h02;
localparam logic [7:0] OPC_RUN   = 8'h03;
localparam logic [7:0] OPC_HALT  = 8'h04;

// Single-byte replies.
localparam logic [7:0] RSP_ACK = 8'h4B;
localparam logic [7:0] RSP_ERR = 8'h3F;

// Operation passed from the decoder to the RAM stage.
typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_ACK,
    OP_ERR
} op_kind_t;

endpackage

/* verilog/uart_rx.sv */
// UART receiver, 8N1, with mid-bit sampling.
// The finished byte sits in a holding register until the valid/ready
// handshake; BAUD_DIV is the clock count per bit.

module uart_rx #(
    parameter int BAUD_DIV = 104
)(
    input  logic       clk_i,
    input  logic       reset_i,

    input  logic       rx_i,
    input  logic       rx_rdy_i,

    output logic [7:0] rx_data_o,
    output logic       rx_vld_o
);

localparam int cnt_w = $clog2(BAUD_DIV);
localparam logic [cnt_w-1:0] full_cnt = cnt_w'(BAUD_DIV - 1);
localparam logic [cnt_w-1:0] half_cnt = cnt_w'(BAUD_DIV / 2 - 1);

typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
} state_t;

state_t           state;
logic             rx_meta;
logic             rx_sync;
logic [cnt_w-1:0] baud_cnt;
logic       [2:0] bit_idx;
logic       [7:0] shreg;
logic             bit_tick;
logic             byte_done;

assign bit_tick  = (baud_cnt == full_cnt);
assign byte_done = (state == RX_STOP) && bit_tick && rx_sync;

// Two-flop synchronizer, idle line is high.
always_ff @(posedge clk_i) begin
    if (reset_i) begin
        rx_meta <= 1'b1;
        rx_sync <= 1'b1;
    end else begin
        rx_meta <= rx_i;
        rx_sync <= rx_meta;
    end
end

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        state    <= RX_IDLE;
        baud_cnt <= '0;
        bit_idx  <= '0;
    end else begin
        case (state)
            RX_IDLE: begin
                baud_cnt <= '0;
                if (!rx_sync) begin
                    state <= RX_START;
                end
            end
            RX_START: begin
                // Recheck the start bit at its middle to reject glitches.
                if (baud_cnt == half_cnt) begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    state    <= rx_sync ? RX_IDLE : RX_DATA;
                end else begin
                    baud_cnt <= baud_cnt + 1'b1;
                end
            end
            RX_DATA: begin
                if (bit_tick) begin
                    baud_cnt <= '0;
                    bit_idx  <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) begin
                        state <= RX_STOP;
                    end
                end else begin
                    baud_cnt <= baud_cnt + 1'b1;
                end
            end
            default: begin
                // A low stop bit is a framing error and the byte is dropped.
                if (bit_tick) begin
                    baud_cnt <= '0;
                    state    <= RX_IDLE;
                end else begin
                    baud_cnt <= baud_cnt + 1'b1;
                end
            end
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if ((state == RX_DATA) && bit_tick) begin
        shreg <= {rx_sync, shreg[7:1]};
    end
    if (byte_done) begin
        rx_data_o <= shreg;
    end
end

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        rx_vld_o <= 1'b0;
    end else if (byte_done) begin
        rx_vld_o <= 1'b1;
    end else if (rx_rdy_i) begin
        rx_vld_o <= 1'b0;
    end
end

// A byte completing while the previous one is still held would be lost.
a_no_overrun: assert property (@(posedge clk_i) disable iff (reset_i)
    byte_done |-> (!rx_vld_o || rx_rdy_i));

endmodule

/* verilog/cmd_decoder.sv */
// Command decoder for the loader protocol.
// Collects the opcode and its argument bytes, then issues one operation
// to the RAM stage and updates the run level for RUN and HALT.

module cmd_decoder(
    input  logic                           clk_i,
    input  logic                           reset_i,

    input  logic                     [7:0] rx_data_i,
    input  logic                           rx_vld_i,
    input  logic                           busy_i,

    output logic                           rx_rdy_o,
    output logic                           op_vld_o,
    output loader_pkg::op_kind_t           op_kind_o,
    output logic [loader_pkg::addr_w-1:0]  op_addr_o,
    output logic   [loader_pkg::xlen-1:0]  op_wdata_o,
    output logic                           run_o
);

logic                         in_cmd;
logic                   [2:0] remain;
logic                   [7:0] opcode;
logic                  [15:0] addr_sr;
logic [loader_pkg::xlen-1:0]  wdata_sr;
logic                   [7:0] cur_opc;
logic                         accept;
logic                         addr_byte;
logic                         cmd_done;
loader_pkg::op_kind_t         next_kind;

// No bytes while a reply is going out, nor in the issue cycle.
assign rx_rdy_o = ~busy_i & ~op_vld_o;
assign accept   = rx_vld_i & rx_rdy_o;

assign cur_opc   = in_cmd ? opcode : rx_data_i;
assign addr_byte = (opcode != loader_pkg::OPC_WRITE) || (remain > 3'd4);

assign cmd_done = accept && (in_cmd ? (remain == 3'd1) :
                  (rx_data_i != loader_pkg::OPC_WRITE &&
                   rx_data_i != loader_pkg::OPC_READ));

always_comb begin
    case (cur_opc)
        loader_pkg::OPC_WRITE: next_kind = loader_pkg::OP_WRITE;
        loader_pkg::OPC_READ:  next_kind = loader_pkg::OP_READ;
        loader_pkg::OPC_RUN,
        loader_pkg::OPC_HALT:  next_kind = loader_pkg::OP_ACK;
        default:               next_kind = loader_pkg::OP_ERR;
    endcase
end

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        in_cmd   <= 1'b0;
        remain   <= '0;
        op_vld_o <= 1'b0;
        run_o    <= 1'b0;
    end else begin
        op_vld_o <= cmd_done;
        if (accept && !in_cmd) begin
            if (rx_data_i == loader_pkg::OPC_WRITE) begin
                in_cmd <= 1'b1;
                remain <= 3'd6;
            end else if (rx_data_i == loader_pkg::OPC_READ) begin
                in_cmd <= 1'b1;
                remain <= 3'd2;
            end
        end else if (accept) begin
            remain <= remain - 1'b1;
            if (remain == 3'd1) begin
                in_cmd <= 1'b0;
            end
        end
        if (cmd_done) begin
            if (cur_opc == loader_pkg::OPC_RUN) begin
                run_o <= 1'b1;
            end else if (cur_opc == loader_pkg::OPC_HALT) begin
                run_o <= 1'b0;
            end
        end
    end
end

// Arguments arrive LSB first and shift in from the top.
always_ff @(posedge clk_i) begin
    if (accept && !in_cmd) begin
        opcode <= rx_data_i;
    end
    if (accept && in_cmd) begin
        if (addr_byte) begin
            addr_sr <= {rx_data_i, addr_sr[15:8]};
        end else begin
            wdata_sr <= {rx_data_i, wdata_sr[loader_pkg::xlen-1:8]};
        end
    end
    if (cmd_done) begin
        op_kind_o <= next_kind;
    end
end

// Upper address bits are ignored.
assign op_addr_o  = addr_sr[loader_pkg::addr_w-1:0];
assign op_wdata_o = wdata_sr;

endmodule

/* verilog/word_ram.sv */
// Word RAM stage of the loader pipeline.
// Executes one operation per op_vld_i pulse and answers one cycle later
// with either a single reply byte or a full 32-bit word.

module word_ram(
    input  logic                           clk_i,
    input  logic                           reset_i,

    input  logic                           op_vld_i,
    input  loader_pkg::op_kind_t           op_kind_i,
    input  logic [loader_pkg::addr_w-1:0]  op_addr_i,
    input  logic   [loader_pkg::xlen-1:0]  op_wdata_i,

    output logic                           rsp_vld_o,
    output logic   [loader_pkg::xlen-1:0]  rsp_word_o,
    output logic                           rsp_len_o
);

localparam int depth = 1 << loader_pkg::addr_w;
localparam int pad_w = loader_pkg::xlen - 8;

logic [loader_pkg::xlen-1:0] mem [0:depth-1];

always_ff @(posedge clk_i) begin
    if (op_vld_i && op_kind_i == loader_pkg::OP_WRITE) begin
        mem[op_addr_i] <= op_wdata_i;
    end
end

always_ff @(posedge clk_i) begin
    if (op_vld_i) begin
        case (op_kind_i)
            loader_pkg::OP_READ: begin
                rsp_word_o <= mem[op_addr_i];
                rsp_len_o  <= 1'b1;
            end
            loader_pkg::OP_ERR: begin
                rsp_word_o <= {{pad_w{1'b0}}, loader_pkg::RSP_ERR};
                rsp_len_o  <= 1'b0;
            end
            default: begin
                rsp_word_o <= {{pad_w{1'b0}}, loader_pkg::RSP_ACK};
                rsp_len_o  <= 1'b0;
            end
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        rsp_vld_o <= 1'b0;
    end else begin
        rsp_vld_o <= op_vld_i;
    end
end

endmodule

/* verilog/reply_serializer.sv */
// Reply serializer between the RAM stage and the UART transmitter.
// Latches a response and hands it to the transmitter one byte per
// handshake, LSB first; busy_o holds off the decoder meanwhile.

module reply_serializer(
    input  logic                          clk_i,
    input  logic                          reset_i,

    input  logic                          rsp_vld_i,
    input  logic  [loader_pkg::xlen-1:0]  rsp_word_i,
    input  logic                          rsp_len_i,
    input  logic                          tx_rdy_i,

    output logic                    [7:0] tx_data_o,
    output logic                          tx_vld_o,
    output logic                          busy_o
);

logic [loader_pkg::xlen-1:0] shreg;
logic                  [2:0] left;
logic                        xfer;

assign xfer      = tx_vld_o & tx_rdy_i;
assign tx_vld_o  = busy_o;
assign tx_data_o = shreg[7:0];

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        busy_o <= 1'b0;
        left   <= '0;
    end else if (rsp_vld_i) begin
        busy_o <= 1'b1;
        left   <= rsp_len_i ? 3'd4 : 3'd1;
    end else if (xfer) begin
        left <= left - 1'b1;
        // Drop busy together with the last byte.
        if (left == 3'd1) begin
            busy_o <= 1'b0;
        end
    end
end

always_ff @(posedge clk_i) begin
    if (rsp_vld_i) begin
        shreg <= rsp_word_i;
    end else if (xfer) begin
        shreg <= {8'h00, shreg[loader_pkg::xlen-1:8]};
    end
end

// The decoder must hold off new commands until the reply is out.
a_no_rsp_when_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_vld_i |-> !busy_o);

endmodule

/* verilog/uart_tx.sv */
// UART transmitter, 8N1.
// Accepts a byte on the valid/ready handshake when idle and shifts out
// start bit, data LSB first and stop bit, BAUD_DIV clocks per bit.

module uart_tx #(
    parameter int BAUD_DIV = 104
)(
    input  logic       clk_i,
    input  logic       reset_i,

    input  logic [7:0] tx_data_i,
    input  logic       tx_vld_i,

    output logic       tx_o,
    output logic       tx_rdy_o
);

localparam int cnt_w = $clog2(BAUD_DIV);
localparam logic [cnt_w-1:0] full_cnt = cnt_w'(BAUD_DIV - 1);

logic             active;
logic       [9:0] frame;
logic       [3:0] bit_cnt;
logic [cnt_w-1:0] baud_cnt;

assign tx_rdy_o = ~active;

// Bit 0 of the frame drives the line; ones shift in behind it.
assign tx_o = frame[0];

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        active   <= 1'b0;
        frame    <= '1;
        bit_cnt  <= '0;
        baud_cnt <= '0;
    end else if (!active) begin
        if (tx_vld_i) begin
            active   <= 1'b1;
            frame    <= {1'b1, tx_data_i, 1'b0};
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end
    end else if (baud_cnt == full_cnt) begin
        baud_cnt <= '0;
        frame    <= {1'b1, frame[9:1]};
        if (bit_cnt == 4'd9) begin
            active <= 1'b0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end else begin
        baud_cnt <= baud_cnt + 1'b1;
    end
end

endmodule

/* verilog/loader_top.sv */
// Board top of the UART memory loader.
// Chains receiver, decoder, word RAM, reply serializer and transmitter,
// and brings out the run level and three status LEDs.

module loader_top #(
    parameter int BAUD_DIV = 104
)(
    input  logic clk_i,
    input  logic reset_i,

    input  logic rx_i,
    output logic tx_o,

    output logic run_o,
    output logic led_run_o,
    output logic led_rx_o,
    output logic led_tx_o
);

logic                    [7:0] rx_data;
logic                          rx_vld;
logic                          rx_rdy;

logic                          op_vld;
loader_pkg::op_kind_t          op_kind;
logic [loader_pkg::addr_w-1:0] op_addr;
logic   [loader_pkg::xlen-1:0] op_wdata;

logic                          rsp_vld;
logic   [loader_pkg::xlen-1:0] rsp_word;
logic                          rsp_len;

logic                    [7:0] tx_data;
logic                          tx_vld;
logic                          tx_rdy;

logic                          busy;
logic                          run;

assign run_o     = run;
assign led_run_o = run;
assign led_rx_o  = rx_vld;
// Lit while a frame is on the line.
assign led_tx_o  = ~tx_rdy;

uart_rx #(
    .BAUD_DIV(BAUD_DIV)
) uart_rx_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .rx_i(rx_i),
    .rx_rdy_i(rx_rdy),
    .rx_data_o(rx_data),
    .rx_vld_o(rx_vld)
);

cmd_decoder cmd_decoder_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .rx_data_i(rx_data),
    .rx_vld_i(rx_vld),
    .busy_i(busy),
    .rx_rdy_o(rx_rdy),
    .op_vld_o(op_vld),
    .op_kind_o(op_kind),
    .op_addr_o(op_addr),
    .op_wdata_o(op_wdata),
    .run_o(run)
);

word_ram word_ram_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .op_vld_i(op_vld),
    .op_kind_i(op_kind),
    .op_addr_i(op_addr),
    .op_wdata_i(op_wdata),
    .rsp_vld_o(rsp_vld),
    .rsp_word_o(rsp_word),
    .rsp_len_o(rsp_len)
);

reply_serializer reply_serializer_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .rsp_vld_i(rsp_vld),
    .rsp_word_i(rsp_word),
    .rsp_len_i(rsp_len),
    .tx_rdy_i(tx_rdy),
    .tx_data_o(tx_data),
    .tx_vld_o(tx_vld),
    .busy_o(busy)
);

uart_tx #(
    .BAUD_DIV(BAUD_DIV)
) uart_tx_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .tx_data_i(tx_data),
    .tx_vld_i(tx_vld),
    .tx_o(tx_o),
    .tx_rdy_o(tx_rdy)
);

endmodule

/* bench/tb_loader.sv */
// Testbench for the UART memory loader.
// A serial host model sends commands on rx_i and a monitor decodes tx_o
// into a reply queue. Assertions compare replies with a reference memory.

module tb_loader;

timeunit 1ns;
timeprecision 100ps;

localparam int BAUD = 8;
// Ten frames of budget per command, for up to 50 commands.
localparam int cmd_budget  = 50;
localparam int cycle_limit = cmd_budget * 10 * 10 * BAUD;

logic        clk_i;
logic        reset_i;
logic        rx_i;
logic        tx_o;
logic        run_o;
logic        led_run_o;
logic        led_rx_o;
logic        led_tx_o;

logic  [7:0] reply_q [$];
logic [31:0] ref_mem [logic [7:0]];
logic        idle_phase = 1'b0;
logic        tx_started = 1'b0;
int          errors = 0;
int          cmds = 0;
int          cycles = 0;

loader_top #(
    .BAUD_DIV(BAUD)
) loader_top_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .rx_i(rx_i),
    .tx_o(tx_o),
    .run_o(run_o),
    .led_run_o(led_run_o),
    .led_rx_o(led_rx_o),
    .led_tx_o(led_tx_o)
);

initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
end

always @(posedge clk_i) begin
    cycles++;
    if (cycles >= cycle_limit) begin
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end
end

task automatic report_value(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
    errors++;
endtask

// One 8N1 frame on rx_i, the line changes on falling edges.
task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
        @(negedge clk_i);
        rx_i = frame[i];
        repeat (BAUD - 1) @(negedge clk_i);
    end
endtask

// Samples one frame of tx_o near mid-bit, once its start bit is seen.
task automatic capture_reply_byte();
    logic [7:0] b;
    int         i;
    tx_started = 1'b1;
    repeat (3) @(negedge clk_i);
    for (i = 0; i < 8; i++) begin
        repeat (BAUD) @(negedge clk_i);
        b[i] = tx_o;
    end
    repeat (BAUD) @(negedge clk_i);
    assert (tx_o == 1'b1) else begin
        $display("Stop bit of a reply frame on tx_o was low");
        errors++;
    end
    reply_q.push_back(b);
endtask

initial begin
    forever begin
        @(negedge clk_i);
        if (!reset_i && !tx_o) begin
            capture_reply_byte();
        end
    end
end

// Waits for n reply bytes, then a little more to catch any extra byte.
task automatic wait_reply(input int n);
    while (reply_q.size() < n) begin
        @(negedge clk_i);
    end
    repeat (12 * BAUD) @(negedge clk_i);
    assert (reply_q.size() == n) else report_value("reply count", 32'(reply_q.size()), 32'(n));
endtask

task automatic do_write(input logic [15:0] addr, input logic [31:0] data);
    logic [7:0] got;
    int         k;
    cmds++;
    send_byte(loader_pkg::OPC_WRITE);
    send_byte(addr[7:0]);
    send_byte(addr[15:8]);
    for (k = 0; k < 4; k++) begin
        send_byte(data[8*k +: 8]);
    end
    wait_reply(1);
    got = reply_q.pop_front();
    assert (got == loader_pkg::RSP_ACK) else report_value("tx_o byte", 32'(got),
                                                         32'(loader_pkg::RSP_ACK));
    reply_q.delete();
    ref_mem[addr[7:0]] = data;
endtask

task automatic do_read(input logic [15:0] addr);
    logic [31:0] word;
    logic [31:0] exp;
    int          k;
    cmds++;
    exp = ref_mem[addr[7:0]];
    send_byte(loader_pkg::OPC_READ);
    send_byte(addr[7:0]);
    send_byte(addr[15:8]);
    wait_reply(4);
    for (k = 0; k < 4; k++) begin
        word[8*k +: 8] = reply_q.pop_front();
    end
    assert (word == exp) else report_value("tx_o word", word, exp);
    reply_q.delete();
endtask

// Commands without arguments, answered by a single byte.
task automatic do_single(input logic [7:0] opc, input logic [7:0] exp);
    logic [7:0] got;
    cmds++;
    send_byte(opc);
    wait_reply(1);
    got = reply_q.pop_front();
    assert (got == exp) else report_value("tx_o byte", 32'(got), 32'(exp));
    reply_q.delete();
endtask

task automatic expect_run(input logic exp);
    assert (run_o == exp) else report_value("run_o", 32'(run_o), 32'(exp));
    assert (led_run_o == exp) else report_value("led_run_o", 32'(led_run_o), 32'(exp));
endtask

a_idle_line: assert property (@(posedge clk_i) disable iff (reset_i)
    idle_phase |-> tx_o)
    else begin
        $display("FAIL tx_o = 0x%h during idle, expected 0x1", $sampled(tx_o));
        errors++;
    end

a_idle_flags: assert property (@(posedge clk_i) disable iff (reset_i)
    idle_phase |-> !(run_o || led_rx_o || led_tx_o))
    else begin
        $display("FAIL {run_o,led_rx_o,led_tx_o} = 0x%h during idle, expected 0x0",
                 $sampled({run_o, led_rx_o, led_tx_o}));
        errors++;
    end

a_tx_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
    !tx_started |-> !led_tx_o)
    else begin
        $display("FAIL led_tx_o = 0x%h before any reply, expected 0x0", $sampled(led_tx_o));
        errors++;
    end

a_led_run: assert property (@(posedge clk_i) disable iff (reset_i)
    led_run_o == run_o)
    else begin
        $display("FAIL led_run_o = 0x%h expected 0x%h", $sampled(led_run_o), $sampled(run_o));
        errors++;
    end

// The line rests high whenever the transmitter is idle.
a_line_rest: assert property (@(posedge clk_i) disable iff (reset_i)
    !led_tx_o |-> tx_o)
    else begin
        $display("FAIL tx_o = 0x%h while led_tx_o is low, expected 0x1", $sampled(tx_o));
        errors++;
    end

initial begin
    logic [15:0] addr;
    logic [31:0] data;
    logic  [7:0] addr_list [$];
    logic  [7:0] tmp;
    int          j;
    int          k;
    int          seed_ret;

    seed_ret = $urandom(89181);
    reset_i  = 1'b1;
    rx_i     = 1'b1;
    repeat (10) @(negedge clk_i);
    reset_i    = 1'b0;
    idle_phase = 1'b1;
    repeat (40) @(negedge clk_i);
    idle_phase = 1'b0;

    do_write(16'h0012, 32'hC0DE_1234);
    do_read(16'h0012);

    // Narrow address range so that some addresses are written twice.
    for (k = 0; k < 20; k++) begin
        addr = {8'($urandom_range(255, 0)), 8'($urandom_range(47, 32))};
        data = $urandom();
        if (!ref_mem.exists(addr[7:0])) begin
            addr_list.push_back(addr[7:0]);
        end
        do_write(addr, data);
    end
    for (k = addr_list.size() - 1; k > 0; k--) begin
        j = $urandom_range(k, 0);
        tmp = addr_list[k];
        addr_list[k] = addr_list[j];
        addr_list[j] = tmp;
    end
    for (k = 0; k < addr_list.size(); k++) begin
        do_read({8'($urandom_range(255, 0)), addr_list[k]});
    end

    do_single(loader_pkg::OPC_RUN, loader_pkg::RSP_ACK);
    expect_run(1'b1);
    do_single(loader_pkg::OPC_HALT, loader_pkg::RSP_ACK);
    expect_run(1'b0);
    do_read(16'h0012);

    do_single(loader_pkg::OPC_RUN, loader_pkg::RSP_ACK);
    do_single(8'h00, loader_pkg::RSP_ERR);
    expect_run(1'b1);
    do_single(8'($urandom_range(255, 5)), loader_pkg::RSP_ERR);
    expect_run(1'b1);
    do_read({8'h00, addr_list[0]});
    do_single(loader_pkg::OPC_HALT, loader_pkg::RSP_ACK);
    do_single(8'hA7, loader_pkg::RSP_ERR);
    expect_run(1'b0);
    do_read(16'h0012);

    $display("Commands: %0d, cycles: %0d, errors: %0d", cmds, cycles, errors);
    if (errors == 0) begin
        $display("TEST PASSED");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule

/* verilog.f */
verilog/loader_pkg.sv
verilog/uart_rx.sv
verilog/cmd_decoder.sv
verilog/word_ram.sv
verilog/reply_serializer.sv
verilog/uart_tx.sv
verilog/loader_top.sv
bench/tb_loader.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the loader testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/100ps --top-module tb_loader \
    -f verilog.f || exit 1
out="$(./obj_dir/Vtb_loader)"
echo "$out"
echo "$out" | grep -qx "TEST PASSED" && exit 0 || exit 1
